// File: sources.f
hdl/mmioMapPkg.sv
hdl/mmioBusPkg.sv
hdl/mmioReqDecode.sv
hdl/mmioRegBank.sv
hdl/mmioReadPath.sv
hdl/mmioClient.sv
dv/mmioClientTb.sv

// File: run.sh
#!/usr/bin/env bash
# Builds the testbench with Verilator, runs it and scans the log for the fail message

cd "$(dirname "$0")" || exit 1

LOG=sim.log
rm -f "$LOG"

verilator --binary --timing --assert -f sources.f --top-module mmioClientTb \
  -Mdir obj_dir -o mmioClientSim > "$LOG" 2>&1 \
  && ./obj_dir/mmioClientSim >> "$LOG" 2>&1 \
  || { cat "$LOG"; echo "Build or simulation returned an error"; exit 1; }

cat "$LOG"

grep -q "SIMULATION FAILED" "$LOG" \
  && { echo "Failure reported in $LOG"; exit 1; } \
  || { echo "No failure reported in $LOG"; exit 0; }

// File: dv/mmioClientTb.sv
`default_nettype none

module mmioClientTb
  import mmioMapPkg::*;
  import mmioBusPkg::*;
();

  localparam int cClkPeriod      = 20;
  localparam int cResetCycles    = 8;
  localparam int cCyclesPerEntry = 12;       // Watchdog budget per table entry
  localparam logic [31:0] cSeed  = 32'd62858;

  // One table row, request plus everything expected after it
  typedef struct packed {
    logic        write;
    logic [7:0]  addr;
    logic [7:0]  wdata;
    mmioStatus_t status;     // Held until accepted
    logic [7:0]  expRdata;
    logic        expErr;
    eth0Ctrl_t   expEth;     // Field outputs after the accepting edge
    nts0Cfg_t    expNts;
    roleCtrl_t   expRole;
  } stimEntry_t;

  logic        piShlClk = 1'b0;
  logic        arstN;
  logic        reqValid;
  mmioReq_t    req;
  logic        reqReady;
  logic        respValid;
  mmioResp_t   resp;
  logic        respReady;
  mmioStatus_t status;
  eth0Ctrl_t   eth0Ctrl;
  nts0Cfg_t    nts0Cfg;
  roleCtrl_t   roleCtrl;

  stimEntry_t  stim [$];
  logic [7:0]  shadow [0:127];   // Reference register image
  logic [31:0] rngState;
  logic        tableBuilt = 1'b0;
  eth0Ctrl_t   defEth;
  nts0Cfg_t    defNts;
  roleCtrl_t   defRole;

  always #(cClkPeriod/2) piShlClk = ~piShlClk;

  mmioClient i_dut (
    .piShlClk  (piShlClk),
    .arstN     (arstN),
    .reqValid  (reqValid),
    .req       (req),
    .reqReady  (reqReady),
    .respValid (respValid),
    .resp      (resp),
    .respReady (respReady),
    .status    (status),
    .eth0Ctrl  (eth0Ctrl),
    .nts0Cfg   (nts0Cfg),
    .roleCtrl  (roleCtrl)
  );

  // ------------------------------
  // Helpers
  // ------------------------------
  function automatic logic [31:0] nextRand();
    rngState = rngState * 32'd1103515245 + 32'd12345;   // Upper bits are the useful ones
    return rngState;
  endfunction

  task automatic checkEq(input logic [255:0] actual, input logic [255:0] expected,
                         input string what);
    if (actual !== expected)
    begin
      $display("CHECK FAILED at %0t: %s, got 0x%0h, expected 0x%0h",
               $time, what, actual, expected);
      $display("SIMULATION FAILED");
      $fatal(1, "Stopped at first mismatch");
    end
  endtask

  // Little endian word from four shadow bytes
  function automatic logic [31:0] wordAt(input logic [6:0] base);
    return {shadow[base + 7'd3], shadow[base + 7'd2], shadow[base + 7'd1], shadow[base]};
  endfunction

  function automatic eth0Ctrl_t decodeEth();
    eth0Ctrl_t e;
    e.rxEqualizerMode = shadow['h11][0];
    e.txDriverSwing   = shadow['h11][7:4];
    e.txPreCursor     = shadow['h12][4:0];
    e.txPostCursor    = shadow['h13][4:0];
    e.pcsLoopbackEn   = shadow['h74][0];     // DIAG_CTRL_1
    e.macLoopbackEn   = shadow['h74][1];
    e.macAddrSwapEn   = shadow['h74][2];
    return e;
  endfunction

  function automatic nts0Cfg_t decodeNts();
    nts0Cfg_t n;
    n.macAddress  = {shadow['h27], shadow['h26], wordAt(7'h22)};   // 0x22 is the low byte
    n.ipAddress   = wordAt(7'h34);
    n.subNetMask  = wordAt(7'h38);
    n.gatewayAddr = wordAt(7'h3C);
    return n;
  endfunction

  function automatic roleCtrl_t decodeRole();
    roleCtrl_t r;
    r.udpEchoCtrl  = shadow['h76][1:0];
    r.udpPostPktEn = shadow['h76][2];
    r.udpCaptPktEn = shadow['h76][3];
    r.tcpEchoCtrl  = shadow['h76][5:4];
    r.tcpPostPktEn = shadow['h76][6];
    r.tcpCaptPktEn = shadow['h76][7];
    r.roleOut      = {shadow['h43], shadow['h42]};
    return r;
  endfunction

  // ------------------------------
  // Reference model and table
  // ------------------------------
  task automatic addEntry(input logic write, input logic [7:0] addr, input logic [7:0] wdata);
    stimEntry_t  e;
    logic [31:0] rnd;
    logic [6:0]  a;
    rnd      = nextRand();
    a        = addr[6:0];
    e.write  = write;
    e.addr   = addr;
    e.wdata  = wdata;
    e.status = rnd[31:12];   // Fresh live inputs per request
    if (addr[7])
    begin
      e.expRdata = 8'h00;    // Out of range, nothing stored
      e.expErr   = 1'b1;
    end
    else
    begin
      e.expErr   = 1'b0;
      e.expRdata = shadow[a];                    // Old value, also on writes
      if (a == 7'h10)
        e.expRdata = {4'b0000, e.status.eth0QpllLock, e.status.eth0CoreReady,
                      e.status.mc1InitCalComplete, e.status.mc0InitCalComplete};
      else if (a == 7'h40)
        e.expRdata = e.status.roleIn[7:0];
      else if (a == 7'h41)
        e.expRdata = e.status.roleIn[15:8];
      if (write && cRegWritable[a])
        shadow[a] = wdata;
    end
    e.expEth  = decodeEth();
    e.expNts  = decodeNts();
    e.expRole = decodeRole();
    stim.push_back(e);
  endtask

  // Random write then read of the same address
  task automatic roundTrip(input logic [7:0] addr);
    logic [31:0] rnd;
    rnd = nextRand();
    addEntry(1'b1, addr, rnd[31:24]);
    addEntry(1'b0, addr, 8'h00);
  endtask

  task automatic buildTable();
    logic [1023:0] defBytes;
    defBytes = cDefRegVal;
    for (int i = 0; i < 128; i++)
    begin
      shadow[7'(i)] = defBytes[7:0];
      defBytes      = defBytes >> 8;
    end
    defEth  = decodeEth();
    defNts  = decodeNts();
    defRole = decodeRole();

    // Reset defaults
    for (int i = 'h00; i <= 'h07; i++)
      addEntry(1'b0, 8'(i), 8'h00);
    for (int i = 'h11; i <= 'h13; i++)
      addEntry(1'b0, 8'(i), 8'h00);
    for (int i = 'h38; i <= 'h3F; i++)
      addEntry(1'b0, 8'(i), 8'h00);
    for (int i = 'h70; i <= 'h73; i++)
      addEntry(1'b0, 8'(i), 8'h00);

    // Every writable byte
    for (int i = 0; i < 128; i++)
      if (cRegWritable[7'(i)])
        roundTrip(8'(i));

    // Read-only bytes drop the write
    roundTrip(8'h00);
    roundTrip(8'h07);
    roundTrip(8'h10);
    roundTrip(8'h40);
    roundTrip(8'h7F);

    // Live status, new inputs each time
    repeat (3)
    begin
      addEntry(1'b0, 8'h10, 8'h00);
      addEntry(1'b0, 8'h40, 8'h00);
      addEntry(1'b0, 8'h41, 8'h00);
    end

    // Out of range, then the aliased low address
    roundTrip(8'h80);
    addEntry(1'b0, 8'h00, 8'h00);
    roundTrip(8'h91);
    addEntry(1'b0, 8'h11, 8'h00);
    roundTrip(8'hC2);
    addEntry(1'b0, 8'h42, 8'h00);
    roundTrip(8'hF4);
    addEntry(1'b0, 8'h74, 8'h00);
    roundTrip(8'hFF);
    addEntry(1'b0, 8'h7F, 8'h00);
  endtask

  // ------------------------------
  // Watchdog
  // ------------------------------
  initial
  begin : watchdog
    wait (tableBuilt);
    #(cResetCycles * cClkPeriod + stim.size() * cCyclesPerEntry * cClkPeriod);
    $display("ERROR: run timed out before all %0d table entries completed", stim.size());
    $display("SIMULATION FAILED");
    $fatal(1, "Timeout");
  end

  // ------------------------------
  // Main sequence
  // ------------------------------
  initial
  begin : mainSeq
    int          idx;
    int          pendIdx;
    logic        pendValid;
    logic        stalled;
    logic        accepted;
    logic [31:0] rnd;
    mmioResp_t   heldResp;
    stimEntry_t  cur;

    arstN     = 1'b0;
    reqValid  = 1'b0;
    req       = '0;
    respReady = 1'b0;
    status    = '0;
    rngState  = cSeed;
    buildTable();
    tableBuilt = 1'b1;

    repeat (cResetCycles) @(posedge piShlClk);
    #1;
    arstN = 1'b1;

    checkEq(256'(respValid), 256'(1'b0), "respValid after reset");
    checkEq(256'(reqReady), 256'(1'b1), "reqReady after reset");
    checkEq(256'(eth0Ctrl), 256'(defEth), "eth0Ctrl reset decode");
    checkEq(256'(nts0Cfg), 256'(defNts), "nts0Cfg reset decode");
    checkEq(256'(roleCtrl), 256'(defRole), "roleCtrl reset decode");

    idx       = 0;
    pendIdx   = 0;
    pendValid = 1'b0;
    stalled   = 1'b0;
    heldResp  = '0;
    while (idx < stim.size() || pendValid)
    begin
      // Drive, 1 unit after the edge
      rnd       = nextRand();
      respReady = (rnd[17:16] != 2'b00);   // Stall about one cycle in four
      if (idx < stim.size())
      begin
        cur       = stim[idx];
        reqValid  = 1'b1;
        req.write = cur.write;
        req.addr  = cur.addr;
        req.wdata = cur.wdata;
        status    = cur.status;
      end
      else
        reqValid = 1'b0;

      // Sample mid cycle
      @(negedge piShlClk);
      if (stalled)
        checkEq(256'(resp), 256'(heldResp), "response changed while stalled");
      checkEq(256'(respValid), 256'(pendValid), "respValid against pending request");
      checkEq(256'(reqReady), 256'(!pendValid || respReady), "reqReady against slot state");
      stalled  = respValid && !respReady;
      heldResp = resp;
      if (respValid && respReady)
      begin
        checkEq(256'(resp.rdata), 256'(stim[pendIdx].expRdata),
                $sformatf("entry %0d rdata", pendIdx));
        checkEq(256'(resp.err), 256'(stim[pendIdx].expErr),
                $sformatf("entry %0d err", pendIdx));
        pendValid = 1'b0;
      end
      accepted = reqValid && reqReady;

      @(posedge piShlClk);
      #1;
      if (accepted)
      begin
        checkEq(256'(respValid), 256'(1'b1), "respValid one cycle after acceptance");
        checkEq(256'(eth0Ctrl), 256'(stim[idx].expEth), $sformatf("entry %0d eth0Ctrl", idx));
        checkEq(256'(nts0Cfg), 256'(stim[idx].expNts), $sformatf("entry %0d nts0Cfg", idx));
        checkEq(256'(roleCtrl), 256'(stim[idx].expRole), $sformatf("entry %0d roleCtrl", idx));
        pendIdx   = idx;
        pendValid = 1'b1;
        idx++;
      end
    end

    $display("SIMULATION PASSED");
    $finish;
  end

endmodule

`default_nettype wire

// File: hdl/mmioClient.sv
`default_nettype none

module mmioClient
  import mmioMapPkg::*;
  import mmioBusPkg::*;
(
  input  wire logic         piShlClk,    // Shell clock, whole client
  input  wire logic         arstN,

  // Host bus
  input  wire logic         reqValid,
  input  wire mmioReq_t     req,
  output logic              reqReady,
  output logic              respValid,
  output mmioResp_t         resp,
  input  wire logic         respReady,

  // Shell status and controls
  input  wire mmioStatus_t  status,
  output eth0Ctrl_t         eth0Ctrl,
  output nts0Cfg_t          nts0Cfg,
  output roleCtrl_t         roleCtrl
);

  logic                                          accept;
  bankWrite_t                                    bankWr;
  logic [cBankCount-1:0]                         bankWrEn;
  bankRead_t                                     rdDesc;
  logic [cBankCount-1:0][cBankBytes*cDataWidth-1:0] bankData;
  logic [cRegCount*cDataWidth-1:0]               regFile;    // Flat view, byte n at 8n

  // ------------------------------
  // Request decode
  // ------------------------------
  mmioReqDecode iReqDecode (
    .piShlClk  (piShlClk),
    .arstN     (arstN),
    .reqValid  (reqValid),
    .req       (req),
    .respValid (respValid),
    .respReady (respReady),
    .reqReady  (reqReady),
    .accept    (accept),
    .bankWr    (bankWr),
    .bankWrEn  (bankWrEn),
    .rdDesc    (rdDesc)
  );

  // One bank per 16 bytes
  for (genvar b = 0; b < cBankCount; b++)
  begin : gBank
    mmioRegBank #(
      .gBankIdx (b)
    ) iRegBank (
      .piShlClk (piShlClk),
      .arstN    (arstN),
      .wrEn     (bankWrEn[b]),
      .bankWr   (bankWr),
      .bankData (bankData[b])
    );
  end

  mmioReadPath iReadPath (
    .piShlClk  (piShlClk),
    .arstN     (arstN),
    .accept    (accept),
    .rdDesc    (rdDesc),
    .bankData  (bankData),
    .status    (status),
    .respReady (respReady),
    .respValid (respValid),
    .resp      (resp)
  );

  // ------------------------------
  // Field unpacking
  // ------------------------------
  assign regFile = bankData;   // Bank 0 lands at the bottom

  // GTH tuning from PHY_ETH0
  assign eth0Ctrl.rxEqualizerMode = regFile[cDataWidth*cPhyEth0];
  assign eth0Ctrl.txDriverSwing   = regFile[cDataWidth*cPhyEth0 + 4 +: 4];
  assign eth0Ctrl.txPreCursor     = regFile[cDataWidth*(cPhyEth0 + 1) +: 5];
  assign eth0Ctrl.txPostCursor    = regFile[cDataWidth*(cPhyEth0 + 2) +: 5];
  assign eth0Ctrl.pcsLoopbackEn   = regFile[cDataWidth*cDiagCtrl1 + 0];   // DIAG_CTRL_1
  assign eth0Ctrl.macLoopbackEn   = regFile[cDataWidth*cDiagCtrl1 + 1];
  assign eth0Ctrl.macAddrSwapEn   = regFile[cDataWidth*cDiagCtrl1 + 2];

  // Byte 0 is the low byte everywhere
  assign nts0Cfg.macAddress  = regFile[cDataWidth*cLy2Mac0 +: 48];
  assign nts0Cfg.ipAddress   = regFile[cDataWidth*cLy3Ip0 +: 32];
  assign nts0Cfg.subNetMask  = regFile[cDataWidth*cLy3Snm0 +: 32];
  assign nts0Cfg.gatewayAddr = regFile[cDataWidth*cLy3Gtw0 +: 32];

  // ROLE controls from DIAG_CTRL_2
  assign roleCtrl.udpEchoCtrl  = regFile[cDataWidth*cDiagCtrl2 + 0 +: 2];
  assign roleCtrl.udpPostPktEn = regFile[cDataWidth*cDiagCtrl2 + 2];
  assign roleCtrl.udpCaptPktEn = regFile[cDataWidth*cDiagCtrl2 + 3];
  assign roleCtrl.tcpEchoCtrl  = regFile[cDataWidth*cDiagCtrl2 + 4 +: 2];
  assign roleCtrl.tcpPostPktEn = regFile[cDataWidth*cDiagCtrl2 + 6];
  assign roleCtrl.tcpCaptPktEn = regFile[cDataWidth*cDiagCtrl2 + 7];
  assign roleCtrl.roleOut      = regFile[cDataWidth*cRoleOut +: 16];   // 0x42 low

endmodule

`default_nettype wire

// File: hdl/mmioReadPath.sv
`default_nettype none

module mmioReadPath
  import mmioMapPkg::*;
  import mmioBusPkg::*;
(
  input  wire logic                                          piShlClk,
  input  wire logic                                          arstN,
  input  wire logic                                          accept,
  input  wire bankRead_t                                     rdDesc,
  input  wire logic [cBankCount-1:0][cBankBytes*cDataWidth-1:0] bankData,
  input  wire mmioStatus_t                                   status,    // Live, sampled on accept
  input  wire logic                                          respReady,
  output logic                                               respValid,
  output mmioResp_t                                          resp
);

  logic [cBankBytes*cDataWidth-1:0] bankSel;
  logic [cDataWidth-1:0]            storedByte;
  logic [cAddrWidth-1:0]            rdAddr;
  logic [cDataWidth-1:0]            liveByte;
  mmioResp_t                        nextResp;

  // ------------------------------
  // Byte select
  // ------------------------------
  assign bankSel    = bankData[rdDesc.bankIdx];
  assign storedByte = bankSel[rdDesc.offset*cDataWidth +: cDataWidth];
  assign rdAddr     = {rdDesc.bankIdx, rdDesc.offset};

  // Status overlay replaces the stored byte
  always_comb
  begin
    liveByte = storedByte;
    if (rdAddr == cPhyStat)
      liveByte = {4'b0000,
                  status.eth0QpllLock,
                  status.eth0CoreReady,
                  status.mc1InitCalComplete,
                  status.mc0InitCalComplete};
    else if (rdAddr == cRoleIn)
      liveByte = status.roleIn[7:0];         // Low byte first
    else if (rdAddr == cRoleIn + 7'd1)
      liveByte = status.roleIn[15:8];
  end

  assign nextResp.rdata = rdDesc.err ? '0 : liveByte;   // Nothing leaks out of range
  assign nextResp.err   = rdDesc.err;

  // ------------------------------
  // Response register
  // ------------------------------
  always_ff @(posedge piShlClk or negedge arstN)
  begin
    if (!arstN)
      respValid <= 1'b0;
    else if (accept)
      respValid <= 1'b1;         // New one replaces any drained one
    else if (respReady)
      respValid <= 1'b0;
  end

  // Payload only moves on accept, so a stall holds it
  always_ff @(posedge piShlClk)
  begin
    if (accept)
      resp <= nextResp;
  end

  // Stalled response must not change under the host
  aRespHold: assert property (
    @(posedge piShlClk) disable iff (!arstN)
    respValid && !respReady |=> respValid && $stable(resp)
  );

endmodule

`default_nettype wire

// File: hdl/mmioRegBank.sv
`default_nettype none

module mmioRegBank
  import mmioMapPkg::*;
  import mmioBusPkg::*;
#(
  parameter int unsigned gBankIdx = 0   // Position in the register space
) (
  input  wire logic                              piShlClk,
  input  wire logic                              arstN,
  input  wire logic                              wrEn,
  input  wire bankWrite_t                        bankWr,
  output logic [cBankBytes*cDataWidth-1:0]       bankData
);

  // This bank's slice of the global tables
  localparam logic [cBankBytes*cDataWidth-1:0] cResetVal =
    cDefRegVal[gBankIdx*cBankBytes*cDataWidth +: cBankBytes*cDataWidth];
  localparam logic [cBankBytes-1:0] cWrMask =
    cRegWritable[gBankIdx*cBankBytes +: cBankBytes];

  logic [cBankBytes-1:0][cDataWidth-1:0] regByte;   // Byte 0 at the bottom

  // ------------------------------
  // Byte storage
  // ------------------------------
  always_ff @(posedge piShlClk or negedge arstN)
  begin
    if (!arstN)
      regByte <= cResetVal;
    else if (wrEn && cWrMask[bankWr.offset])   // RO bytes drop the write
      regByte[bankWr.offset] <= bankWr.data;
  end

  assign bankData = regByte;

  // Read-only bytes stay at their reset value forever
  for (genvar i = 0; i < cBankBytes; i++)
  begin : gRoCheck
    if (!cWrMask[i])
    begin : gRo
      aRoByteHeld: assert property (
        @(posedge piShlClk) disable iff (!arstN)
        bankData[i*cDataWidth +: cDataWidth] == cResetVal[i*cDataWidth +: cDataWidth]
      );
    end
  end

endmodule

`default_nettype wire

// File: hdl/mmioReqDecode.sv
`default_nettype none

module mmioReqDecode
  import mmioMapPkg::*;
  import mmioBusPkg::*;
(
  input  wire logic               piShlClk,
  input  wire logic               arstN,
  input  wire logic               reqValid,
  input  wire mmioReq_t           req,
  input  wire logic               respValid,   // Response slot occupied
  input  wire logic               respReady,
  output logic                    reqReady,
  output logic                    accept,      // Request taken this edge
  output bankWrite_t              bankWr,
  output logic [cBankCount-1:0]   bankWrEn,
  output bankRead_t               rdDesc
);

  logic outOfRange;
  logic wrHit;

  // ------------------------------
  // Handshake
  // ------------------------------
  // Slot frees up when empty or drained this cycle
  assign reqReady = !respValid || respReady;
  assign accept   = reqValid && reqReady;

  // ------------------------------
  // Address split
  // ------------------------------
  assign outOfRange     = req.addr[cAddrWidth];                        // Bit 7
  assign rdDesc.bankIdx = req.addr[cAddrWidth-1:cOffsWidth];
  assign rdDesc.offset  = req.addr[cOffsWidth-1:0];
  assign rdDesc.err     = outOfRange;

  // Broadcast to all banks, only the enabled one listens
  assign bankWr.offset  = req.addr[cOffsWidth-1:0];
  assign bankWr.data    = req.wdata;

  // Error writes never reach a bank
  assign wrHit    = accept && req.write && !outOfRange;
  assign bankWrEn = wrHit ? (cBankCount'(1) << rdDesc.bankIdx) : '0;

  // At most one bank written per edge
  aBankWrOneHot: assert property (
    @(posedge piShlClk) disable iff (!arstN)
    $onehot0(bankWrEn)
  );

endmodule

`default_nettype wire

// File: hdl/mmioBusPkg.sv
`default_nettype none

package mmioBusPkg;

  // Host address carries one extra bit above the register space
  localparam int cHostAddrWidth = mmioMapPkg::cAddrWidth + 1;
  localparam int cBankIdxWidth  = $clog2(mmioMapPkg::cBankCount);

  // ------------------------------
  // Host side request / response
  // ------------------------------
  typedef struct packed {
    logic                                write;   // 1 = write, 0 = read
    logic [cHostAddrWidth-1:0]           addr;    // Bit 7 set is out of range
    logic [mmioMapPkg::cDataWidth-1:0]   wdata;
  } mmioReq_t;

  typedef struct packed {
    logic [mmioMapPkg::cDataWidth-1:0]   rdata;   // Old value on a write
    logic                                err;
  } mmioResp_t;

  // ------------------------------
  // Internal bank traffic
  // ------------------------------
  typedef struct packed {
    logic [mmioMapPkg::cOffsWidth-1:0]   offset;  // Same for every bank
    logic [mmioMapPkg::cDataWidth-1:0]   data;
  } bankWrite_t;

  typedef struct packed {
    logic [cBankIdxWidth-1:0]            bankIdx;
    logic [mmioMapPkg::cOffsWidth-1:0]   offset;
    logic                                err;     // Address beyond 0x7F
  } bankRead_t;

endpackage

`default_nettype wire

// File: hdl/mmioMapPkg.sv
`default_nettype none

package mmioMapPkg;

  // ------------------------------
  // Geometry of the register space
  // ------------------------------
  localparam int cAddrWidth = 7;                     // Byte address within the space
  localparam int cDataWidth = 8;                     // One byte per register
  localparam int cBankCount = 8;
  localparam int cBankBytes = 16;
  localparam int cOffsWidth = 4;                     // In-bank byte offset
  localparam int cRegCount  = cBankCount * cBankBytes;

  // Register addresses
  localparam logic [cAddrWidth-1:0] cCfgEmifId    = 7'h00;  // Start of EMIF identity
  localparam logic [cAddrWidth-1:0] cCfgTopId     = 7'h04;  // Start of TOP identity
  localparam logic [cAddrWidth-1:0] cPhyStat      = 7'h10;  // Live status, read only
  localparam logic [cAddrWidth-1:0] cPhyEth0      = 7'h11;  // Three GTH tuning bytes
  localparam logic [cAddrWidth-1:0] cLy2Mac0      = 7'h22;  // MAC, six bytes
  localparam logic [cAddrWidth-1:0] cLy3Ip0       = 7'h34;
  localparam logic [cAddrWidth-1:0] cLy3Snm0      = 7'h38;
  localparam logic [cAddrWidth-1:0] cLy3Gtw0      = 7'h3C;
  localparam logic [cAddrWidth-1:0] cRoleIn       = 7'h40;  // From ROLE, two bytes
  localparam logic [cAddrWidth-1:0] cRoleOut      = 7'h42;  // To ROLE, two bytes
  localparam logic [cAddrWidth-1:0] cDiagScratch0 = 7'h70;
  localparam logic [cAddrWidth-1:0] cDiagCtrl1    = 7'h74;  // Loopback enables
  localparam logic [cAddrWidth-1:0] cDiagCtrl2    = 7'h76;  // ROLE echo/post/capture

  // Identity and build stamp
  localparam logic [cDataWidth-1:0] cEmifId       = 8'h3C;  // User variant
  localparam logic [cDataWidth-1:0] cEmifVer      = 8'h01;
  localparam logic [cDataWidth-1:0] cEmifRev      = 8'h00;
  localparam logic [cDataWidth-1:0] cTopId        = 8'h81;  // User variant
  localparam logic [cDataWidth-1:0] cTopDateYear  = 8'hFF;
  localparam logic [cDataWidth-1:0] cTopDateMonth = 8'hFF;
  localparam logic [cDataWidth-1:0] cTopDateDay   = 8'hFF;

  // Byte n sits at bits [8n+7:8n]
  function automatic logic [cRegCount*cDataWidth-1:0] defRegValInit();
    logic [cRegCount*cDataWidth-1:0] v;
    v = '0;
    v[cDataWidth*cCfgEmifId +: 32]    = {8'h33, cEmifRev, cEmifVer, cEmifId};
    v[cDataWidth*cCfgTopId +: 32]     = {cTopDateDay, cTopDateMonth, cTopDateYear, cTopId};
    v[cDataWidth*cPhyEth0 +: 24]      = 24'h05_05_41;  // Swing 4, pre 5, post 5
    v[cDataWidth*cLy3Snm0 +: 32]      = 32'h0000_FFFF; // 255.255.0.0
    v[cDataWidth*cLy3Gtw0 +: 32]      = 32'hFE00_0C0A; // 10.12.0.254
    v[cDataWidth*cDiagScratch0 +: 32] = 32'hEFBE_ADDE; // DE AD BE EF upward
    return v;
  endfunction

  localparam logic [cRegCount*cDataWidth-1:0] cDefRegVal = defRegValInit();

  // One bit per byte, bank 7 on the left
  localparam logic [cRegCount-1:0] cRegWritable = {
    16'h005F,   // DIAG 0x70-74, 0x76
    16'h0000,   // Spare
    16'h0000,   // Spare
    16'h000C,   // ROLE out 0x42-43
    16'hFFF3,   // LY3 ctrl, IP, mask, gateway
    16'h00FD,   // LY2 ctrl and MAC
    16'h000E,   // PHY_ETH0
    16'h0000    // CFG identity is read only
  };

  // ------------------------------
  // Decoded control fields
  // ------------------------------
  typedef struct packed {
    logic       rxEqualizerMode;
    logic [3:0] txDriverSwing;
    logic [4:0] txPreCursor;
    logic [4:0] txPostCursor;
    logic       pcsLoopbackEn;
    logic       macLoopbackEn;
    logic       macAddrSwapEn;
  } eth0Ctrl_t;

  typedef struct packed {
    logic [47:0] macAddress;
    logic [31:0] ipAddress;
    logic [31:0] subNetMask;
    logic [31:0] gatewayAddr;
  } nts0Cfg_t;

  typedef struct packed {
    logic [1:0]  udpEchoCtrl;
    logic        udpPostPktEn;
    logic        udpCaptPktEn;
    logic [1:0]  tcpEchoCtrl;
    logic        tcpPostPktEn;
    logic        tcpCaptPktEn;
    logic [15:0] roleOut;
  } roleCtrl_t;

  // Live inputs overlaid on reads
  typedef struct packed {
    logic        mc0InitCalComplete;
    logic        mc1InitCalComplete;
    logic        eth0CoreReady;
    logic        eth0QpllLock;
    logic [15:0] roleIn;
  } mmioStatus_t;

endpackage

`default_nettype wire
